/* source/npu_pkg.sv */
package npu_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////
   localparam int FILTER_ADDR_W = 11;
   localparam int ACT_ADDR_W    = 13;
   localparam int NUM_BANKS     = 32;
   localparam int ROW_CNT_W     = 6;
   localparam int CLASS_W       = 5;

   typedef logic [FILTER_ADDR_W-1:0] filter_addr_t;
   typedef logic [ACT_ADDR_W-1:0]    act_addr_t;
   typedef logic [NUM_BANKS-1:0]     bank_mask_t;

   //////////////////////////////////////////////////
   // Layer dimensions
   //////////////////////////////////////////////////
   localparam int KERNEL_DIM  = 3;
   localparam int CONV1_IN_CH = 3;
   localparam int CONV2_IN_CH = 8;
   localparam int CONV3_IN_CH = 16;

   // Output quads per row and per column
   localparam int CONV1_QUADS = 16;
   localparam int CONV2_QUADS = 8;
   localparam int CONV3_QUADS = 4;

   // FC1 input is the flattened 4x4x24 conv3 output
   localparam int FC1_DIM            = 4;
   localparam int FC1_IN_CH          = 24;
   localparam int FC2_LEN            = 64;
   localparam int RESULT_WAIT_CYCLES = 64;

   //////////////////////////////////////////////////
   // Memory map
   //////////////////////////////////////////////////
   // Spans are 27, 72, 144, 384, 384 and 64 words
   localparam filter_addr_t CONV1_FILTER_START = 11'd0;
   localparam filter_addr_t CONV1_FILTER_END   = CONV1_FILTER_START + 11'd26;
   localparam filter_addr_t CONV2_FILTER_START = 11'd27;
   localparam filter_addr_t CONV2_FILTER_END   = CONV2_FILTER_START + 11'd71;
   localparam filter_addr_t CONV3_FILTER_START = 11'd99;
   localparam filter_addr_t CONV3_FILTER_END   = CONV3_FILTER_START + 11'd143;
   localparam filter_addr_t FC1_1_FILTER_START = 11'd243;
   localparam filter_addr_t FC1_1_FILTER_END   = FC1_1_FILTER_START + 11'd383;
   localparam filter_addr_t FC1_2_FILTER_START = 11'd627;
   localparam filter_addr_t FC1_2_FILTER_END   = FC1_2_FILTER_START + 11'd383;
   localparam filter_addr_t FC2_FILTER_START   = 11'd1011;
   localparam filter_addr_t FC2_FILTER_END     = FC2_FILTER_START + 11'd63;

   localparam bank_mask_t CONV_FILTER_EN = '1;
   localparam bank_mask_t FC1_FILTER_EN  = '1;
   localparam bank_mask_t FC2_FILTER_EN  = 32'h0000_03ff;

   localparam act_addr_t CONV3_OUTPUT_START = 13'd5120;
   localparam act_addr_t FC1_OUTPUT_START   = 13'd5504;

   //////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////
   typedef enum logic [3:0] {
      IDLE, CONV1, WAIT_CONV1, CONV2, WAIT_CONV2, CONV3, WAIT_CONV3,
      FC1_1, WAIT_FC1_1, FC1_2, WAIT_FC1_2, FC2, SOFTMAX, DONE
   } npu_state_e;

   typedef struct packed {
      logic dp_first;
      logic dp_last;
      logic layer_last;
      logic wait_done;
   } loop_evt_t;

   // One step of read work ahead of the read pipeline
   typedef struct packed {
      logic       valid;
      npu_state_e layer_state;
      logic       dp_first;
      logic       dp_last;
      act_addr_t  fc_act_offset;
   } rd_req_t;

endpackage

/* source/npu_seq_fsm.sv */
`timescale 1ns/10ps

module npu_seq_fsm (
   input  logic                npu_clk,
   input  logic                npu_rst_n,
   input  logic                start_trigger,
   input  npu_pkg::loop_evt_t  evt,
   input  logic                softmax_result_valid_p,
   input  logic                cfg_write_row_p,
   output npu_pkg::npu_state_e state,
   output logic [2:0]          npu_layer_in_progress,
   output logic                npu_active,
   output logic                npu_done,
   output logic                done_entry
);

   npu_pkg::npu_state_e nxt_state;
   logic                done_d;

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         state  <= npu_pkg::IDLE;
         done_d <= 1'b0;
      end else begin
         state  <= nxt_state;
         done_d <= npu_done;
      end
   end

   // Next state and layer number, wait states report the layer they follow
   always_comb begin
      nxt_state             = state;
      npu_layer_in_progress = 3'd0;
      case (state)
         npu_pkg::IDLE: begin
            if (start_trigger) nxt_state = npu_pkg::CONV1;
         end
         npu_pkg::CONV1: begin
            npu_layer_in_progress = 3'd1;
            if (evt.layer_last) nxt_state = npu_pkg::WAIT_CONV1;
         end
         npu_pkg::WAIT_CONV1: begin
            npu_layer_in_progress = 3'd1;
            if (evt.wait_done) nxt_state = npu_pkg::CONV2;
         end
         npu_pkg::CONV2: begin
            npu_layer_in_progress = 3'd2;
            if (evt.layer_last) nxt_state = npu_pkg::WAIT_CONV2;
         end
         npu_pkg::WAIT_CONV2: begin
            npu_layer_in_progress = 3'd2;
            if (evt.wait_done) nxt_state = npu_pkg::CONV3;
         end
         npu_pkg::CONV3: begin
            npu_layer_in_progress = 3'd3;
            if (evt.layer_last) nxt_state = npu_pkg::WAIT_CONV3;
         end
         npu_pkg::WAIT_CONV3: begin
            npu_layer_in_progress = 3'd3;
            if (evt.wait_done) nxt_state = npu_pkg::FC1_1;
         end
         npu_pkg::FC1_1: begin
            npu_layer_in_progress = 3'd4;
            if (evt.layer_last) nxt_state = npu_pkg::WAIT_FC1_1;
         end
         npu_pkg::WAIT_FC1_1: begin
            npu_layer_in_progress = 3'd4;
            if (evt.wait_done) nxt_state = npu_pkg::FC1_2;
         end
         npu_pkg::FC1_2: begin
            npu_layer_in_progress = 3'd5;
            if (evt.layer_last) nxt_state = npu_pkg::WAIT_FC1_2;
         end
         npu_pkg::WAIT_FC1_2: begin
            npu_layer_in_progress = 3'd5;
            if (evt.wait_done) nxt_state = npu_pkg::FC2;
         end
         npu_pkg::FC2: begin
            npu_layer_in_progress = 3'd6;
            if (evt.layer_last) nxt_state = npu_pkg::SOFTMAX;
         end
         npu_pkg::SOFTMAX: begin
            npu_layer_in_progress = 3'd7;
            if (softmax_result_valid_p) nxt_state = npu_pkg::DONE;
         end
         npu_pkg::DONE: begin
            // Held until the host starts writing the next image
            npu_layer_in_progress = 3'd7;
            if (cfg_write_row_p) nxt_state = npu_pkg::IDLE;
         end
         default: nxt_state = npu_pkg::IDLE;
      endcase
   end

   assign npu_done   = (state == npu_pkg::DONE);
   assign npu_active = (state != npu_pkg::IDLE) && !npu_done;
   assign done_entry = npu_done && !done_d;

endmodule

/* source/npu_loop_counters.sv */
`timescale 1ns/10ps

module npu_loop_counters (
   input  logic                npu_clk,
   input  logic                npu_rst_n,
   input  npu_pkg::npu_state_e state,
   output npu_pkg::loop_evt_t  evt,
   output npu_pkg::rd_req_t    req
);

   logic [1:0] filt_col;
   logic [1:0] filt_row;
   logic [3:0] in_ch;
   logic [1:0] quad_pos;
   logic [3:0] quad_col;
   logic [3:0] quad_row;
   logic [3:0] in_ch_max;
   logic [3:0] quad_max;
   logic [1:0] fc1_row;
   logic [1:0] fc1_col;
   logic [4:0] fc1_ch;
   logic [5:0] fc2_cnt;
   logic [5:0] wait_cnt;
   logic       conv_st;
   logic       fc1_st;
   logic       fc2_st;
   logic       wait_st;
   logic       conv_dp_last;
   logic       conv_layer_last;
   logic       fc1_last;
   logic       fc2_last;

   assign conv_st = state inside {npu_pkg::CONV1, npu_pkg::CONV2, npu_pkg::CONV3};
   assign fc1_st  = state inside {npu_pkg::FC1_1, npu_pkg::FC1_2};
   assign fc2_st  = (state == npu_pkg::FC2);
   assign wait_st = state inside {npu_pkg::WAIT_CONV1, npu_pkg::WAIT_CONV2,
                                  npu_pkg::WAIT_CONV3, npu_pkg::WAIT_FC1_1,
                                  npu_pkg::WAIT_FC1_2};

   // Channel and quad limits of the current conv layer
   always_comb begin
      case (state)
         npu_pkg::CONV1: begin
            in_ch_max = 4'(npu_pkg::CONV1_IN_CH - 1);
            quad_max  = 4'(npu_pkg::CONV1_QUADS - 1);
         end
         npu_pkg::CONV2: begin
            in_ch_max = 4'(npu_pkg::CONV2_IN_CH - 1);
            quad_max  = 4'(npu_pkg::CONV2_QUADS - 1);
         end
         default: begin
            in_ch_max = 4'(npu_pkg::CONV3_IN_CH - 1);
            quad_max  = 4'(npu_pkg::CONV3_QUADS - 1);
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Boundary events
   //////////////////////////////////////////////////
   assign conv_dp_last    = (filt_col == 2'(npu_pkg::KERNEL_DIM - 1)) && (in_ch == in_ch_max) &&
                            (filt_row == 2'(npu_pkg::KERNEL_DIM - 1));
   // Last pixel of the quad is bottom-right
   assign conv_layer_last = conv_dp_last && (quad_pos == 2'd3) &&
                            (quad_col == quad_max) && (quad_row == quad_max);
   assign fc1_last        = (fc1_row == 2'(npu_pkg::FC1_DIM - 1)) &&
                            (fc1_col == 2'(npu_pkg::FC1_DIM - 1)) &&
                            (fc1_ch == 5'(npu_pkg::FC1_IN_CH - 1));
   assign fc2_last        = (fc2_cnt == 6'(npu_pkg::FC2_LEN - 1));

   always_comb begin
      evt.dp_first   = (conv_st && filt_col == 2'd0 && in_ch == 4'd0 && filt_row == 2'd0) ||
                       (fc1_st && fc1_row == 2'd0 && fc1_col == 2'd0 && fc1_ch == 5'd0) ||
                       (fc2_st && fc2_cnt == 6'd0);
      evt.dp_last    = (conv_st && conv_dp_last) || (fc1_st && fc1_last) || (fc2_st && fc2_last);
      evt.layer_last = (conv_st && conv_layer_last) || (fc1_st && fc1_last) ||
                       (fc2_st && fc2_last);
      evt.wait_done  = wait_st && (wait_cnt == 6'(npu_pkg::RESULT_WAIT_CYCLES - 1));

      req.valid       = conv_st || fc1_st || fc2_st;
      req.layer_state = state;
      req.dp_first    = evt.dp_first;
      req.dp_last     = evt.dp_last;
      // Flatten order is row first, then column, then channel
      if (fc1_st) begin
         req.fc_act_offset = npu_pkg::act_addr_t'(fc1_ch * npu_pkg::FC1_DIM * npu_pkg::FC1_DIM +
                                                  fc1_row * npu_pkg::FC1_DIM + fc1_col);
      end else if (fc2_st) begin
         req.fc_act_offset = npu_pkg::act_addr_t'(fc2_cnt);
      end else begin
         req.fc_act_offset = '0;
      end
   end

   //////////////////////////////////////////////////
   // Counters
   //////////////////////////////////////////////////
   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         filt_col <= '0;
         filt_row <= '0;
         in_ch    <= '0;
         quad_pos <= '0;
         quad_col <= '0;
         quad_row <= '0;
      end else if (!conv_st) begin
         filt_col <= '0;
         filt_row <= '0;
         in_ch    <= '0;
         quad_pos <= '0;
         quad_col <= '0;
         quad_row <= '0;
      end else if (filt_col != 2'(npu_pkg::KERNEL_DIM - 1)) begin
         filt_col <= filt_col + 2'd1;
      end else begin
         filt_col <= '0;
         if (in_ch != in_ch_max) begin
            in_ch <= in_ch + 4'd1;
         end else begin
            in_ch <= '0;
            if (filt_row != 2'(npu_pkg::KERNEL_DIM - 1)) begin
               filt_row <= filt_row + 2'd1;
            end else begin
               // One output pixel done, step through the quad
               filt_row <= '0;
               quad_pos <= quad_pos + 2'd1;
               if (quad_pos == 2'd3) begin
                  quad_col <= (quad_col == quad_max) ? 4'd0 : quad_col + 4'd1;
                  if (quad_col == quad_max) begin
                     quad_row <= (quad_row == quad_max) ? 4'd0 : quad_row + 4'd1;
                  end
               end
            end
         end
      end
   end

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         fc1_row  <= '0;
         fc1_col  <= '0;
         fc1_ch   <= '0;
         fc2_cnt  <= '0;
         wait_cnt <= '0;
      end else begin
         if (!fc1_st) begin
            fc1_row <= '0;
            fc1_col <= '0;
            fc1_ch  <= '0;
         end else begin
            fc1_row <= fc1_row + 2'd1;
            if (fc1_row == 2'(npu_pkg::FC1_DIM - 1)) begin
               fc1_col <= fc1_col + 2'd1;
               if (fc1_col == 2'(npu_pkg::FC1_DIM - 1)) begin
                  fc1_ch <= fc1_last ? 5'd0 : fc1_ch + 5'd1;
               end
            end
         end
         fc2_cnt  <= fc2_st ? fc2_cnt + 6'd1 : 6'd0;
         wait_cnt <= wait_st ? wait_cnt + 6'd1 : 6'd0;
      end
   end

endmodule

/* source/npu_mem_rd_gen.sv */
`timescale 1ns/10ps

module npu_mem_rd_gen (
   input  logic                                npu_clk,
   input  logic                                npu_rst_n,
   input  npu_pkg::rd_req_t                    req,
   output logic [npu_pkg::NUM_BANKS-1:0]       filter_mem_rd_en,
   output logic [npu_pkg::FILTER_ADDR_W-1:0]   filter_mem_rd_addr,
   output logic                                activation_mem_rd_en,
   output logic [npu_pkg::ACT_ADDR_W-1:0]      activation_mem_rd_addr,
   output logic [npu_pkg::NUM_BANKS-1:0]       mac_enable,
   output logic                                mac_start_p,
   output logic                                mac_last_p
);

   npu_pkg::rd_req_t     pipe [3];
   npu_pkg::filter_addr_t start_addr;
   npu_pkg::filter_addr_t end_addr;
   npu_pkg::bank_mask_t   rd_mask;
   npu_pkg::bank_mask_t   mac_mask;
   npu_pkg::act_addr_t    act_base;
   logic                  fc_step;
   logic                  layer_first;

   // Per-layer filter window and bank mask
   function automatic npu_pkg::bank_mask_t bank_mask(npu_pkg::npu_state_e st);
      case (st)
         npu_pkg::CONV1, npu_pkg::CONV2, npu_pkg::CONV3: bank_mask = npu_pkg::CONV_FILTER_EN;
         npu_pkg::FC1_1, npu_pkg::FC1_2:                 bank_mask = npu_pkg::FC1_FILTER_EN;
         npu_pkg::FC2:                                   bank_mask = npu_pkg::FC2_FILTER_EN;
         default:                                        bank_mask = '0;
      endcase
   endfunction

   always_comb begin
      case (pipe[1].layer_state)
         npu_pkg::CONV1: {start_addr, end_addr} = {npu_pkg::CONV1_FILTER_START,
                                                   npu_pkg::CONV1_FILTER_END};
         npu_pkg::CONV2: {start_addr, end_addr} = {npu_pkg::CONV2_FILTER_START,
                                                   npu_pkg::CONV2_FILTER_END};
         npu_pkg::CONV3: {start_addr, end_addr} = {npu_pkg::CONV3_FILTER_START,
                                                   npu_pkg::CONV3_FILTER_END};
         npu_pkg::FC1_1: {start_addr, end_addr} = {npu_pkg::FC1_1_FILTER_START,
                                                   npu_pkg::FC1_1_FILTER_END};
         npu_pkg::FC1_2: {start_addr, end_addr} = {npu_pkg::FC1_2_FILTER_START,
                                                   npu_pkg::FC1_2_FILTER_END};
         default:        {start_addr, end_addr} = {npu_pkg::FC2_FILTER_START,
                                                   npu_pkg::FC2_FILTER_END};
      endcase
   end

   assign rd_mask  = pipe[1].valid ? bank_mask(pipe[1].layer_state) : '0;
   assign mac_mask = pipe[2].valid ? bank_mask(pipe[2].layer_state) : '0;
   assign fc_step  = pipe[1].valid &&
                     (pipe[1].layer_state inside {npu_pkg::FC1_1, npu_pkg::FC1_2, npu_pkg::FC2});
   // FC1 reads the conv3 output, FC2 reads the FC1 output
   assign act_base = (pipe[1].layer_state == npu_pkg::FC2) ? npu_pkg::FC1_OUTPUT_START
                                                           : npu_pkg::CONV3_OUTPUT_START;
   // Stage 2 holds the step just before the one in stage 1
   assign layer_first = pipe[1].valid &&
                        (!pipe[2].valid || pipe[2].layer_state != pipe[1].layer_state);

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         pipe                   <= '{default: '0};
         filter_mem_rd_en       <= '0;
         filter_mem_rd_addr     <= '0;
         activation_mem_rd_en   <= 1'b0;
         activation_mem_rd_addr <= '0;
         mac_enable             <= '0;
         mac_start_p            <= 1'b0;
         mac_last_p             <= 1'b0;
      end else begin
         pipe[0] <= req;
         pipe[1] <= pipe[0];
         pipe[2] <= pipe[1];

         // Read side, third cycle after the counter step
         filter_mem_rd_en       <= rd_mask;
         activation_mem_rd_en   <= fc_step;
         activation_mem_rd_addr <= fc_step ? act_base + pipe[1].fc_act_offset : '0;
         if (layer_first) begin
            filter_mem_rd_addr <= start_addr;
         end else if (pipe[1].valid) begin
            filter_mem_rd_addr <= (filter_mem_rd_addr == end_addr) ? start_addr
                                                                   : filter_mem_rd_addr + 11'd1;
         end

         // MAC framing, one cycle behind the read data
         mac_enable  <= mac_mask;
         mac_start_p <= pipe[2].valid && pipe[2].dp_first;
         mac_last_p  <= pipe[2].valid && pipe[2].dp_last;
      end
   end

endmodule

/* source/npu_status_regs.sv */
`timescale 1ns/10ps

module npu_status_regs (
   input  logic                           npu_clk,
   input  logic                           npu_rst_n,
   input  logic                           cfg_write_row_p,
   input  logic [npu_pkg::ROW_CNT_W-1:0]  cfg_thrshld_num_rows_to_start,
   input  logic                           done_entry,
   input  logic                           softmax_result_valid_p,
   input  logic [npu_pkg::CLASS_W-1:0]    softmax_class_predicted,
   output logic [npu_pkg::ROW_CNT_W-1:0]  img_num_rows_written,
   output logic                           start_trigger,
   output logic [npu_pkg::CLASS_W-1:0]    npu_class_predicted
);

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         img_num_rows_written <= '0;
         npu_class_predicted  <= '0;
      end else begin
         // Row count restarts once the image is classified
         if (done_entry) begin
            img_num_rows_written <= '0;
         end else if (cfg_write_row_p) begin
            img_num_rows_written <= img_num_rows_written + 6'd1;
         end
         if (softmax_result_valid_p) begin
            npu_class_predicted <= softmax_class_predicted;
         end
      end
   end

   // A zero threshold never starts the engine
   assign start_trigger = (img_num_rows_written >= cfg_thrshld_num_rows_to_start) &&
                          (|cfg_thrshld_num_rows_to_start);

endmodule

/* source/npu_control_top.sv */
`timescale 1ns/10ps

module npu_control_top (
   input  logic                                npu_clk,
   input  logic                                npu_rst_n,
   input  logic                                cfg_write_row_p,
   input  logic [npu_pkg::ROW_CNT_W-1:0]       cfg_thrshld_num_rows_to_start,
   input  logic                                softmax_result_valid_p,
   input  logic [npu_pkg::CLASS_W-1:0]         softmax_class_predicted,
   output logic                                npu_active,
   output logic                                npu_done,
   output logic [2:0]                          npu_layer_in_progress,
   output logic [npu_pkg::ROW_CNT_W-1:0]       img_num_rows_written,
   output logic [npu_pkg::CLASS_W-1:0]         npu_class_predicted,
   output logic [npu_pkg::NUM_BANKS-1:0]       mac_enable,
   output logic                                mac_start_p,
   output logic                                mac_last_p,
   output logic [npu_pkg::NUM_BANKS-1:0]       filter_mem_rd_en,
   output logic [npu_pkg::FILTER_ADDR_W-1:0]   filter_mem_rd_addr,
   output logic                                activation_mem_rd_en,
   output logic [npu_pkg::ACT_ADDR_W-1:0]      activation_mem_rd_addr
);

   npu_pkg::npu_state_e state;
   npu_pkg::loop_evt_t  evt;
   npu_pkg::rd_req_t    req;
   logic                start_trigger;
   logic                done_entry;

   npu_seq_fsm u_seq_fsm (
      .npu_clk                (npu_clk),
      .npu_rst_n              (npu_rst_n),
      .start_trigger          (start_trigger),
      .evt                    (evt),
      .softmax_result_valid_p (softmax_result_valid_p),
      .cfg_write_row_p        (cfg_write_row_p),
      .state                  (state),
      .npu_layer_in_progress  (npu_layer_in_progress),
      .npu_active             (npu_active),
      .npu_done               (npu_done),
      .done_entry             (done_entry)
   );

   npu_loop_counters u_loop_counters (
      .npu_clk   (npu_clk),
      .npu_rst_n (npu_rst_n),
      .state     (state),
      .evt       (evt),
      .req       (req)
   );

   npu_mem_rd_gen u_mem_rd_gen (
      .npu_clk                (npu_clk),
      .npu_rst_n              (npu_rst_n),
      .req                    (req),
      .filter_mem_rd_en       (filter_mem_rd_en),
      .filter_mem_rd_addr     (filter_mem_rd_addr),
      .activation_mem_rd_en   (activation_mem_rd_en),
      .activation_mem_rd_addr (activation_mem_rd_addr),
      .mac_enable             (mac_enable),
      .mac_start_p            (mac_start_p),
      .mac_last_p             (mac_last_p)
   );

   npu_status_regs u_status_regs (
      .npu_clk                       (npu_clk),
      .npu_rst_n                     (npu_rst_n),
      .cfg_write_row_p               (cfg_write_row_p),
      .cfg_thrshld_num_rows_to_start (cfg_thrshld_num_rows_to_start),
      .done_entry                    (done_entry),
      .softmax_result_valid_p        (softmax_result_valid_p),
      .softmax_class_predicted       (softmax_class_predicted),
      .img_num_rows_written          (img_num_rows_written),
      .start_trigger                 (start_trigger),
      .npu_class_predicted           (npu_class_predicted)
   );

endmodule

/* sim/tb_npu_control.sv */
`timescale 1ns/10ps

module tb_npu_control;

   logic                                npu_clk;
   logic                                npu_rst_n;
   logic                                cfg_write_row_p;
   logic [npu_pkg::ROW_CNT_W-1:0]       cfg_thrshld_num_rows_to_start;
   logic                                softmax_result_valid_p;
   logic [npu_pkg::CLASS_W-1:0]         softmax_class_predicted;
   logic                                npu_active;
   logic                                npu_done;
   logic [2:0]                          npu_layer_in_progress;
   logic [npu_pkg::ROW_CNT_W-1:0]       img_num_rows_written;
   logic [npu_pkg::CLASS_W-1:0]         npu_class_predicted;
   logic [npu_pkg::NUM_BANKS-1:0]       mac_enable;
   logic                                mac_start_p;
   logic                                mac_last_p;
   logic [npu_pkg::NUM_BANKS-1:0]       filter_mem_rd_en;
   logic [npu_pkg::FILTER_ADDR_W-1:0]   filter_mem_rd_addr;
   logic                                activation_mem_rd_en;
   logic [npu_pkg::ACT_ADDR_W-1:0]      activation_mem_rd_addr;

   int          errors;
   int          checks;
   logic [31:0] lcg_state;
   logic [2:0]  lay_hist [5];
   logic [2:0]  prev_layer;
   logic [2:0]  lay_seq [$];
   int          start_cnt [8];
   int          last_cnt [8];
   int          filt_cnt [8];
   int          act_cnt [8];
   int          mac_cnt [8];
   int          wd_cycles;

   npu_control_top dut (.*);

   initial npu_clk = 1'b0;
   always #20 npu_clk = ~npu_clk;

   //////////////////////////////////////////////////
   // Reference values
   //////////////////////////////////////////////////
   function automatic int layer_steps(input logic [2:0] lay);
      case (lay)
         3'd1: return npu_pkg::CONV1_QUADS * npu_pkg::CONV1_QUADS * 4 * 9 * npu_pkg::CONV1_IN_CH;
         3'd2: return npu_pkg::CONV2_QUADS * npu_pkg::CONV2_QUADS * 4 * 9 * npu_pkg::CONV2_IN_CH;
         3'd3: return npu_pkg::CONV3_QUADS * npu_pkg::CONV3_QUADS * 4 * 9 * npu_pkg::CONV3_IN_CH;
         3'd4, 3'd5: return 384;
         3'd6: return 64;
         default: return 0;
      endcase
   endfunction

   // Dot products per layer, one per output pixel for conv
   function automatic int layer_dps(input logic [2:0] lay);
      case (lay)
         3'd1: return npu_pkg::CONV1_QUADS * npu_pkg::CONV1_QUADS * 4;
         3'd2: return npu_pkg::CONV2_QUADS * npu_pkg::CONV2_QUADS * 4;
         3'd3: return npu_pkg::CONV3_QUADS * npu_pkg::CONV3_QUADS * 4;
         3'd4, 3'd5, 3'd6: return 1;
         default: return 0;
      endcase
   endfunction

   function automatic int filt_start(input logic [2:0] lay);
      case (lay)
         3'd1: return 0;
         3'd2: return 27;
         3'd3: return 99;
         3'd4: return 243;
         3'd5: return 627;
         default: return 1011;
      endcase
   endfunction

   function automatic int filt_span(input logic [2:0] lay);
      case (lay)
         3'd1: return 27;
         3'd2: return 72;
         3'd3: return 144;
         3'd4, 3'd5: return 384;
         default: return 64;
      endcase
   endfunction

   function automatic int inference_cycles();
      int total;
      total = 5 * 64 + 200;
      for (int l = 1; l <= 6; l++) begin
         total += layer_steps(3'(l));
      end
      return total;
   endfunction

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_error(input string what);
      errors++;
      $display("Error at %0t: %s", $time, what);
   endtask

   //////////////////////////////////////////////////
   // Output monitor, sampled mid-cycle
   //////////////////////////////////////////////////
   always @(negedge npu_clk) begin
      if (npu_rst_n) begin
         for (int i = 4; i > 0; i--) begin
            lay_hist[i] = lay_hist[i-1];
         end
         lay_hist[0] = npu_layer_in_progress;
         if (npu_layer_in_progress != prev_layer) begin
            lay_seq.push_back(npu_layer_in_progress);
            prev_layer = npu_layer_in_progress;
         end

         // Reads trail their step by 3 cycles, MAC framing by 4
         if (filter_mem_rd_en != '0) begin
            if (lay_hist[3] inside {[3'd1:3'd6]}) begin
               check_val("filter_mem_rd_addr", 32'(filter_mem_rd_addr),
                         32'(filt_start(lay_hist[3]) +
                             filt_cnt[lay_hist[3]] % filt_span(lay_hist[3])));
               check_val("filter_mem_rd_en", filter_mem_rd_en,
                         (lay_hist[3] == 3'd6) ? 32'h0000_03ff : 32'hffff_ffff);
               filt_cnt[lay_hist[3]]++;
            end else begin
               report_error("filter read outside a compute layer");
            end
         end
         if (activation_mem_rd_en) begin
            if (lay_hist[3] inside {3'd4, 3'd5}) begin
               check_val("activation_mem_rd_addr", 32'(activation_mem_rd_addr),
                         5120 + (act_cnt[lay_hist[3]] / 16) * 16 +
                         (act_cnt[lay_hist[3]] % 4) * 4 + (act_cnt[lay_hist[3]] / 4) % 4);
               act_cnt[lay_hist[3]]++;
            end else if (lay_hist[3] == 3'd6) begin
               check_val("activation_mem_rd_addr", 32'(activation_mem_rd_addr),
                         5504 + act_cnt[6]);
               act_cnt[6]++;
            end else begin
               report_error("activation read outside a fully connected layer");
            end
         end
         if (mac_enable != '0) begin
            if (lay_hist[4] inside {[3'd1:3'd6]}) begin
               check_val("mac_enable", mac_enable,
                         (lay_hist[4] == 3'd6) ? 32'h0000_03ff : 32'hffff_ffff);
               mac_cnt[lay_hist[4]]++;
            end else begin
               report_error("MAC enable outside a compute layer");
            end
         end
         if (mac_start_p) begin
            if (lay_hist[4] inside {[3'd1:3'd6]}) start_cnt[lay_hist[4]]++;
            else report_error("MAC start pulse outside a compute layer");
         end
         if (mac_last_p) begin
            if (lay_hist[4] inside {[3'd1:3'd6]}) last_cnt[lay_hist[4]]++;
            else report_error("MAC last pulse outside a compute layer");
         end
      end
   end

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////
   task automatic pulse_row();
      @(posedge npu_clk);
      #2 cfg_write_row_p = 1'b1;
      @(posedge npu_clk);
      #2 cfg_write_row_p = 1'b0;
   endtask

   task automatic wait_for_layer(input logic [2:0] lay);
      do begin
         @(posedge npu_clk);
         #2;
      end while (npu_layer_in_progress != lay);
   endtask

   task automatic check_reset();
      check_val("npu_layer_in_progress", 32'(npu_layer_in_progress), 32'd0);
      check_val("npu_active", 32'(npu_active), 32'd0);
      check_val("npu_done", 32'(npu_done), 32'd0);
      check_val("mac_enable", mac_enable, 32'd0);
      check_val("mac_start_p", 32'(mac_start_p), 32'd0);
      check_val("mac_last_p", 32'(mac_last_p), 32'd0);
      check_val("filter_mem_rd_en", filter_mem_rd_en, 32'd0);
      check_val("activation_mem_rd_en", 32'(activation_mem_rd_en), 32'd0);
   endtask

   task automatic row_trigger_test();
      repeat (3) pulse_row();
      @(posedge npu_clk);
      #2;
      check_val("img_num_rows_written", 32'(img_num_rows_written), 32'd3);
      check_val("npu_active", 32'(npu_active), 32'd0);
      check_val("npu_layer_in_progress", 32'(npu_layer_in_progress), 32'd0);
      pulse_row();
      check_val("img_num_rows_written", 32'(img_num_rows_written), 32'd4);
      // Count meets the threshold, CONV1 follows one cycle later
      @(posedge npu_clk);
      #2;
      check_val("npu_active", 32'(npu_active), 32'd1);
      check_val("npu_layer_in_progress", 32'(npu_layer_in_progress), 32'd1);
   endtask

   task automatic inference_test();
      logic [31:0] r;
      logic [4:0]  cls;
      wait_for_layer(3'd7);
      check_val("npu_active", 32'(npu_active), 32'd1);
      check_val("npu_done", 32'(npu_done), 32'd0);
      repeat (9) @(posedge npu_clk);
      #2;
      r = lcg_next();
      cls = r[20:16];
      softmax_result_valid_p = 1'b1;
      softmax_class_predicted = cls;
      @(posedge npu_clk);
      #2 softmax_result_valid_p = 1'b0;
      check_val("npu_done", 32'(npu_done), 32'd1);
      check_val("npu_active", 32'(npu_active), 32'd0);
      check_val("npu_class_predicted", 32'(npu_class_predicted), 32'(cls));
      @(posedge npu_clk);
      #2;
      check_val("img_num_rows_written", 32'(img_num_rows_written), 32'd0);
   endtask

   task automatic restart_test();
      pulse_row();
      check_val("npu_layer_in_progress", 32'(npu_layer_in_progress), 32'd0);
      check_val("npu_done", 32'(npu_done), 32'd0);
      check_val("npu_active", 32'(npu_active), 32'd0);
      check_val("img_num_rows_written", 32'(img_num_rows_written), 32'd1);
   endtask

   task automatic check_layer_totals();
      logic [2:0] lay;
      // Let the monitor record the return to idle
      @(posedge npu_clk);
      #2;
      for (int l = 1; l <= 6; l++) begin
         lay = 3'(l);
         check_val($sformatf("mac_start_p count layer %0d", l), start_cnt[l], layer_dps(lay));
         check_val($sformatf("mac_last_p count layer %0d", l), last_cnt[l], layer_dps(lay));
         check_val($sformatf("filter read count layer %0d", l), filt_cnt[l], layer_steps(lay));
         check_val($sformatf("mac_enable count layer %0d", l), mac_cnt[l], layer_steps(lay));
         check_val($sformatf("activation read count layer %0d", l), act_cnt[l],
                   (l >= 4) ? layer_steps(lay) : 0);
      end
      // Layers 1 to 7 in order, then back to idle
      check_val("layer change count", lay_seq.size(), 32'd8);
      for (int i = 0; i < lay_seq.size() && i < 8; i++) begin
         check_val($sformatf("layer sequence entry %0d", i), 32'(lay_seq[i]), (i + 1) % 8);
      end
   endtask

   //////////////////////////////////////////////////
   // Watchdog and main sequence
   //////////////////////////////////////////////////
   initial begin
      wd_cycles = 2 * inference_cycles();
      repeat (wd_cycles) @(posedge npu_clk);
      $display("Timeout: the run did not finish within %0d cycles", wd_cycles);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      errors = 0;
      checks = 0;
      lcg_state = 32'h1cfe_9e91;
      prev_layer = 3'd0;
      lay_hist = '{default: 3'd0};
      npu_rst_n = 1'b0;
      cfg_write_row_p = 1'b0;
      cfg_thrshld_num_rows_to_start = 6'd4;
      softmax_result_valid_p = 1'b0;
      softmax_class_predicted = '0;
      repeat (2) @(posedge npu_clk);
      #2 npu_rst_n = 1'b1;

      check_reset();
      row_trigger_test();
      inference_test();
      restart_test();
      check_layer_totals();

      $display("Checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* files.f */
source/npu_pkg.sv
source/npu_seq_fsm.sv
source/npu_loop_counters.sv
source/npu_mem_rd_gen.sv
source/npu_status_regs.sv
source/npu_control_top.sv
sim/tb_npu_control.sv

/* Makefile */
TOP := tb_npu_control

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
